// ==== Bender.yml ====
package:
  name: upcore

sources:
  - files:
      - hw/upPkg.sv
      - hw/upMemory.sv
      - hw/upDecoder.sv
      - hw/upAlu.sv
      - hw/upControl.sv
      - hw/upHostPort.sv
      - hw/upTop.sv
  - target: test
    files:
      - dv/upTb.sv

// ==== dv/upTb.sv ====
`default_nettype none

module upTb;

	import upPkg::*;

	localparam int cycleLimit = 20000;
	localparam int stepLimit = 1500;

	logic clk;
	logic nRst;
	logic hostValid;
	logic hostWrite;
	byteT hostAddr;
	byteT hostWdata;
	logic hostReady;
	logic rspValid;
	byteT rspData;
	logic rspReady;
	logic startReq;
	logic halted;
	byteT watch;

	// Expected memory contents and core registers, carried from run to run
	byteT model [0:255];
	byteT modelAcc;
	logic modelZero;
	logic modelCarry;
	int modelCycles; // Cycles from first fetch until halted rises
	byteT wp;

	integer seed = 32'hdd44b3ac;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int runStart;

	upTop #(
		.watchAddr (8'd127)
	) uut (
		.clk       (clk),
		.nRst      (nRst),
		.hostValid (hostValid),
		.hostWrite (hostWrite),
		.hostAddr  (hostAddr),
		.hostWdata (hostWdata),
		.hostReady (hostReady),
		.rspValid  (rspValid),
		.rspData   (rspData),
		.rspReady  (rspReady),
		.startReq  (startReq),
		.halted    (halted),
		.watch     (watch)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// Executes the image in model[] from address 0, returns the step count or -1 on runaway
	function automatic int runModel();
		byteT pc;
		byteT argPc;
		byteT arg;
		logic [3:0] op;
		logic wroteAcc;
		int steps;
		pc = 8'h00;
		steps = 0;
		modelCycles = 0;
		while (steps < stepLimit) begin
			steps++;
			op = model[pc][7:4];
			argPc = pc + 8'd1;
			arg = model[argPc];
			wroteAcc = 1'b1;
			case (op)
				4'hF: begin
					modelCycles += 1; // Fetch, then straight to halt
					return steps;
				end
				4'hC: begin
					modelCarry = modelAcc[7];
					modelAcc = {modelAcc[6:0], 1'b0};
				end
				4'hD: begin
					modelCarry = modelAcc[0];
					modelAcc = {1'b0, modelAcc[7:1]};
				end
				4'h0, 4'hE: wroteAcc = 1'b0;
				default: ;
			endcase
			if (op == 4'h0 || op == 4'hE || op == 4'hC || op == 4'hD) begin
				pc = pc + 8'd1;
				modelCycles += 2;
			end else begin
				pc = pc + 8'd2;
				modelCycles += (op >= 4'h8) ? 2 : 3; // Memory operands take an extra cycle
				wroteAcc = 1'b1;
				case (op)
					4'h1: modelAcc = model[arg];
					4'h3: begin
						modelCarry = (9'(modelAcc) + 9'(model[arg])) > 9'd255;
						modelAcc = modelAcc + model[arg];
					end
					4'h4: begin
						modelCarry = modelAcc >= model[arg]; // No borrow
						modelAcc = modelAcc - model[arg];
					end
					4'h5: modelAcc = modelAcc & model[arg];
					4'h6: modelAcc = modelAcc | model[arg];
					4'h7: modelAcc = modelAcc ^ model[arg];
					4'h8: modelAcc = arg;
					default: begin
						wroteAcc = 1'b0;
						if (op == 4'h2) model[arg] = modelAcc;
						if (op == 4'h9 || (op == 4'hA && modelZero) || (op == 4'hB && modelCarry))
							pc = arg;
					end
				endcase
			end
			if (wroteAcc) modelZero = (modelAcc == 8'h00);
		end
		return -1;
	endfunction

	task automatic checkByte(input byteT actual, input byteT expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic predictRun();
		if (runModel() < 0) begin
			errors++;
			$display("The reference model ran past its step limit of %0d", stepLimit);
		end
	endtask

	task automatic waitReady();
		do @(negedge clk); while (!hostReady);
	endtask

	task automatic waitHalted();
		do begin
			@(negedge clk);
			if (!halted) checkByte(hostReady, 1'b0, "host ready while running");
		end while (!halted);
	endtask

	task automatic writeByte(input byteT addr, input byteT data);
		@(posedge clk);
		hostValid <= 1'b1;
		hostWrite <= 1'b1;
		hostAddr <= addr;
		hostWdata <= data;
		waitReady();
		@(posedge clk);
		hostValid <= 1'b0;
		model[addr] = data;
		@(negedge clk);
		checkByte(watch, model[127], "watch after host write");
	endtask

	task automatic readByte(input byteT addr, input int hold, output byteT data);
		@(posedge clk);
		hostValid <= 1'b1;
		hostWrite <= 1'b0;
		hostAddr <= addr;
		rspReady <= 1'b0;
		waitReady();
		@(posedge clk);
		hostValid <= 1'b0;
		@(negedge clk);
		checkByte(rspValid, 1'b1, "response valid after read");
		checkByte(hostReady, 1'b0, "host ready with response pending");
		data = rspData;
		repeat (hold) begin
			@(negedge clk);
			checkByte(rspValid, 1'b1, "response held under back-pressure");
			checkByte(rspData, data, "response data stable");
			checkByte(hostReady, 1'b0, "host ready under back-pressure");
		end
		@(posedge clk);
		rspReady <= 1'b1;
		@(posedge clk);
		rspReady <= 1'b0;
		@(negedge clk);
		checkByte(rspValid, 1'b0, "response taken only once");
	endtask

	task automatic readCheck(input byteT addr, input int hold);
		byteT data;
		readByte(addr, hold, data);
		checkByte(data, model[addr], $sformatf("read of address %h", addr));
	endtask

	task automatic emit(input byteT b);
		model[wp] = b;
		wp = wp + 8'd1;
	endtask

	task automatic emit2(input opcodeT op, input byteT arg);
		emit({op, 4'h0});
		emit(arg);
	endtask

	task automatic loadProgram();
		for (int a = 0; a < int'(wp); a++) writeByte(byteT'(a), model[a]);
	endtask

	task automatic startRun();
		@(posedge clk);
		startReq <= 1'b1;
		waitReady();
		@(posedge clk);
		startReq <= 1'b0;
		@(negedge clk);
		runStart = cycles;
		checkByte(halted, 1'b0, "core running after start");
	endtask

	initial begin
		byteT addrs [0:11];
		byteT n;
		nRst = 1'b0;
		hostValid = 1'b0;
		hostWrite = 1'b0;
		hostAddr = 8'h00;
		hostWdata = 8'h00;
		rspReady = 1'b0;
		startReq = 1'b0;
		for (int i = 0; i < 256; i++) model[i] = 8'h00;
		// Boot program: lda 0E, add 0F, sta 7F, hlt, with its two data bytes
		model[0] = 8'h10;
		model[1] = 8'h0E;
		model[2] = 8'h30;
		model[3] = 8'h0F;
		model[4] = 8'h20;
		model[5] = 8'h7F;
		model[6] = 8'hF0;
		model[14] = 8'h5B;
		model[15] = 8'hA5;
		modelAcc = 8'h00;
		modelZero = 1'b0;
		modelCarry = 1'b0;

		@(posedge clk);
		@(negedge clk);
		checkByte(halted, 1'b0, "halted in reset");
		checkByte(hostReady, 1'b0, "host ready in reset");
		checkByte(rspValid, 1'b0, "response valid in reset");
		@(posedge clk);
		nRst <= 1'b1;

		predictRun();
		waitHalted();
		checkByte(watch, model[127], "boot result on watch");
		for (int a = 0; a <= 20; a++) readCheck(byteT'(a), 0);

		// Random writes, then read back with random back-pressure
		for (int i = 0; i < 12; i++) begin
			addrs[i] = (i == 0) ? 8'd127 : byteT'($random(seed));
			writeByte(addrs[i], byteT'($random(seed)));
		end
		for (int i = 0; i < 12; i++) readCheck(addrs[i], $random(seed) & 7);

		// Every ALU opcode on random operands, each result to its own address
		wp = 8'h00;
		for (int i = 0; i < 5; i++) begin
			writeByte(byteT'(8'h60 + i), byteT'($random(seed)));
			emit2(opLdi, byteT'($random(seed)));
			emit2(opcodeT'(opAdd + i), byteT'(8'h60 + i));
			emit2(opSta, byteT'(8'h80 + i));
		end
		emit2(opLdi, byteT'($random(seed)));
		emit({opShl, 4'h0});
		emit2(opSta, 8'h85);
		emit({opShr, 4'h0});
		emit2(opSta, 8'h86);
		emit2(opLda, 8'h60);
		emit2(opSta, 8'h87);
		emit(8'h00);
		emit(8'hE5); // Unused code with a nonzero low nibble
		emit({opHlt, 4'h0});
		loadProgram();
		predictRun();
		startRun();
		waitHalted();
		checkByte(byteT'(cycles - runStart), byteT'(modelCycles), "ALU program run length");
		for (int a = 8'h80; a <= 8'h87; a++) readCheck(byteT'(a), $random(seed) & 3);

		// Countdown loop, with start requests during the run
		n = byteT'(3 + ($random(seed) & 7));
		writeByte(8'h70, 8'h01);
		wp = 8'h00;
		emit2(opLdi, n);
		emit2(opSta, 8'h7F);
		emit2(opSub, 8'h70);
		emit2(opJz, 8'h0C);
		emit2(opJc, 8'h02);
		emit2(opJmp, 8'h0E);
		emit2(opJmp, 8'h10);
		emit({opHlt, 4'h0});
		emit(8'h00);
		emit2(opSta, 8'h7E);
		emit({opHlt, 4'h0});
		loadProgram();
		predictRun();
		startRun();
		repeat (4) begin
			@(posedge clk);
			startReq <= 1'b1;
		end
		@(posedge clk);
		startReq <= 1'b0;
		waitHalted();
		// A restart during the run would make it longer than the model predicts
		checkByte(byteT'(cycles - runStart), byteT'(modelCycles), "loop run length");
		checkByte(watch, model[127], "loop result on watch");
		readCheck(8'h7E, 2);
		readCheck(8'h7F, 0);
		readCheck(8'h70, 1);

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/upAlu.sv ====
`default_nettype none

module upAlu (
	input  wire upPkg::aluOpT op,
	input  wire upPkg::byteT  acc,
	input  wire upPkg::byteT  operand,
	input  wire               carryIn,
	output upPkg::byteT       result,
	output logic              carryOut,
	output logic              zero
);

	import upPkg::*;

	logic [8:0] sum;

	always_comb begin
		sum = '0;
		result = operand;
		carryOut = carryIn;
		case (op)
			aluPass: result = operand;
			aluAdd: begin
				sum = {1'b0, acc} + {1'b0, operand};
				result = sum[7:0];
				carryOut = sum[8];
			end
			aluSub: begin
				sum = {1'b0, acc} - {1'b0, operand};
				result = sum[7:0];
				carryOut = ~sum[8]; // Set when there is no borrow
			end
			aluAnd: result = acc & operand;
			aluOr: result = acc | operand;
			aluXor: result = acc ^ operand;
			aluShl: begin
				result = {acc[6:0], 1'b0};
				carryOut = acc[7];
			end
			aluShr: begin
				result = {1'b0, acc[7:1]};
				carryOut = acc[0];
			end
			default: result = operand;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== hw/upControl.sv ====
`default_nettype none

module upControl (
	input  wire              clk,
	input  wire              nRst,
	input  wire upPkg::byteT rdata,
	input  wire              start,
	output upPkg::addrT      coreAddr,
	output upPkg::byteT      coreWdata,
	output logic             coreWe,
	output logic             halted
);

	import upPkg::*;

	ctrlStateT state;
	addrT pc;
	opcodeT instr;
	addrT operand;
	byteT acc;
	logic zeroFlag;
	logic carryFlag;

	opcodeT curOp;
	aluOpT aluOp;
	logic hasOperand, readsMemory, writesMemory, writesAcc, isJump, isHalt;
	byteT aluResult;
	logic aluCarry, aluZero;
	logic takeJump;
	logic accUpdate;

	// Decode the byte on the bus while fetching, the latched opcode after that
	assign curOp = (state == stFetch) ? opcodeT'(rdata[7:4]) : instr;

	upDecoder decoder (
		.opcode       (curOp),
		.aluOp        (aluOp),
		.hasOperand   (hasOperand),
		.readsMemory  (readsMemory),
		.writesMemory (writesMemory),
		.writesAcc    (writesAcc),
		.isJump       (isJump),
		.isHalt       (isHalt)
	);

	upAlu alu (
		.op       (aluOp),
		.acc      (acc),
		.operand  (rdata), // Immediate in stOperand, memory byte in stExec
		.carryIn  (carryFlag),
		.result   (aluResult),
		.carryOut (aluCarry),
		.zero     (aluZero)
	);

	always_comb begin
		case (instr)
			opJz: takeJump = zeroFlag;
			opJc: takeJump = carryFlag;
			default: takeJump = 1'b1;
		endcase
	end

	// Ldi loads in stOperand, everything else that writes acc does so in stExec
	assign accUpdate = writesAcc &&
		((state == stOperand && !readsMemory) || state == stExec);

	assign coreAddr = (state == stExec) ? operand : pc;
	assign coreWdata = acc;
	assign coreWe = (state == stExec) && writesMemory;
	assign halted = (state == stHalt);

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= stFetch;
			pc <= '0;
			acc <= '0;
			zeroFlag <= 1'b0;
			carryFlag <= 1'b0;
		end else begin
			if (accUpdate) begin
				acc <= aluResult;
				zeroFlag <= aluZero;
				carryFlag <= aluCarry;
			end
			case (state)
				stFetch: begin
					pc <= pc + 8'd1;
					if (isHalt) state <= stHalt;
					else if (hasOperand) state <= stOperand;
					else state <= stExec;
				end
				stOperand: begin
					pc <= (isJump && takeJump) ? rdata : pc + 8'd1;
					state <= (readsMemory || writesMemory) ? stExec : stFetch;
				end
				stExec: state <= stFetch;
				stHalt: begin
					if (start) begin
						pc <= '0;
						state <= stFetch;
					end
				end
				default: state <= stHalt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == stFetch) instr <= curOp;
		if (state == stOperand) operand <= rdata;
	end

endmodule

`default_nettype wire

// ==== hw/upDecoder.sv ====
`default_nettype none

module upDecoder (
	input  wire upPkg::opcodeT opcode,
	output upPkg::aluOpT       aluOp,
	output logic               hasOperand,
	output logic               readsMemory,
	output logic               writesMemory,
	output logic               writesAcc,
	output logic               isJump,
	output logic               isHalt
);

	import upPkg::*;

	always_comb begin
		aluOp = aluPass;
		hasOperand = 1'b0;
		readsMemory = 1'b0;
		writesMemory = 1'b0;
		writesAcc = 1'b0;
		isJump = 1'b0;
		isHalt = 1'b0;
		case (opcode)
			opLda: begin
				hasOperand = 1'b1;
				readsMemory = 1'b1;
				writesAcc = 1'b1;
			end
			opSta: begin
				hasOperand = 1'b1;
				writesMemory = 1'b1;
			end
			opAdd, opSub, opAnd, opOr, opXor: begin
				hasOperand = 1'b1;
				readsMemory = 1'b1;
				writesAcc = 1'b1;
				case (opcode)
					opAdd: aluOp = aluAdd;
					opSub: aluOp = aluSub;
					opAnd: aluOp = aluAnd;
					opOr: aluOp = aluOr;
					default: aluOp = aluXor;
				endcase
			end
			opLdi: begin
				hasOperand = 1'b1; // Immediate taken straight from the operand byte
				writesAcc = 1'b1;
			end
			opJmp, opJz, opJc: begin
				hasOperand = 1'b1;
				isJump = 1'b1;
			end
			opShl: begin
				writesAcc = 1'b1;
				aluOp = aluShl;
			end
			opShr: begin
				writesAcc = 1'b1;
				aluOp = aluShr;
			end
			opHlt: isHalt = 1'b1;
			default: ; // Nop and the unused code
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/upHostPort.sv ====
`default_nettype none

module upHostPort (
	input  wire              clk,
	input  wire              nRst,
	input  wire              halted,
	input  wire upPkg::addrT coreAddr,
	input  wire upPkg::byteT coreWdata,
	input  wire              coreWe,
	input  wire              hostValid,
	input  wire              hostWrite,
	input  wire upPkg::addrT hostAddr,
	input  wire upPkg::byteT hostWdata,
	input  wire              rspReady,
	input  wire upPkg::byteT rdata,
	input  wire              startReq,
	output logic             hostReady,
	output logic             rspValid,
	output upPkg::byteT      rspData,
	output upPkg::addrT      address,
	output upPkg::byteT      wdata,
	output logic             we,
	output logic             start
);

	import upPkg::*;

	logic accept;

	// A pending response blocks new requests
	assign hostReady = halted && !rspValid;
	assign accept = hostValid && hostReady;
	assign start = startReq && hostReady;

	// Core owns the memory whenever it runs
	assign address = halted ? hostAddr : coreAddr;
	assign wdata = halted ? hostWdata : coreWdata;
	assign we = halted ? (accept && hostWrite) : coreWe;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			rspValid <= 1'b0;
		end else if (accept && !hostWrite) begin
			rspValid <= 1'b1;
		end else if (rspReady) begin
			rspValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !hostWrite) rspData <= rdata; // Held until the host takes it
	end

endmodule

`default_nettype wire

// ==== hw/upMemory.sv ====
`default_nettype none

module upMemory #(
	parameter upPkg::addrT watchAddr = 8'd127
) (
	input  wire              clk,
	input  wire              nRst,
	input  wire upPkg::addrT address,
	input  wire upPkg::byteT wdata,
	input  wire              we,
	output upPkg::byteT      rdata,
	output upPkg::byteT      watch
);

	import upPkg::*;

	localparam int depth = 256;

	byteT mem [0:depth-1];

	// Reads are combinational so the core sees data in the same cycle
	assign rdata = mem[address];
	assign watch = mem[watchAddr];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < bootLength; i++) begin
				mem[i] <= bootImage[i];
			end
			for (int i = bootLength; i < depth; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[address] <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== hw/upPkg.sv ====
`default_nettype none

package upPkg;

	typedef logic [7:0] byteT;
	typedef logic [7:0] addrT;

	// High nibble of the opcode byte, code E is unused and runs as a no-op
	typedef enum logic [3:0] {
		opNop = 4'h0,
		opLda = 4'h1,
		opSta = 4'h2,
		opAdd = 4'h3,
		opSub = 4'h4,
		opAnd = 4'h5,
		opOr  = 4'h6,
		opXor = 4'h7,
		opLdi = 4'h8,
		opJmp = 4'h9,
		opJz  = 4'hA,
		opJc  = 4'hB,
		opShl = 4'hC,
		opShr = 4'hD,
		opHlt = 4'hF
	} opcodeT;

	typedef enum logic [2:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluShl,
		aluShr
	} aluOpT;

	typedef enum logic [2:0] {
		stFetch,
		stOperand,
		stExec,
		stHalt
	} ctrlStateT;

	localparam int bootLength = 16;

	// Adds the two data bytes at the end of the image and stores the sum to 0x7F
	localparam byteT bootImage [0:bootLength-1] = '{
		{opLda, 4'h0}, 8'h0E,
		{opAdd, 4'h0}, 8'h0F,
		{opSta, 4'h0}, 8'h7F,
		{opHlt, 4'h0},
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		8'h5B, 8'hA5
	};

endpackage

`default_nettype wire

// ==== hw/upTop.sv ====
`default_nettype none

module upTop #(
	parameter upPkg::addrT watchAddr = 8'd127
) (
	input  wire              clk,
	input  wire              nRst,
	input  wire              hostValid,
	input  wire              hostWrite,
	input  wire upPkg::addrT hostAddr,
	input  wire upPkg::byteT hostWdata,
	output logic             hostReady,
	output logic             rspValid,
	output upPkg::byteT      rspData,
	input  wire              rspReady,
	input  wire              startReq,
	output logic             halted,
	output upPkg::byteT      watch
);

	import upPkg::*;

	addrT coreAddr, address;
	byteT coreWdata, wdata, rdata;
	logic coreWe, we, start;

	upControl control (
		.clk       (clk),
		.nRst      (nRst),
		.rdata     (rdata),
		.start     (start),
		.coreAddr  (coreAddr),
		.coreWdata (coreWdata),
		.coreWe    (coreWe),
		.halted    (halted)
	);

	upHostPort hostPort (
		.clk       (clk),
		.nRst      (nRst),
		.halted    (halted),
		.coreAddr  (coreAddr),
		.coreWdata (coreWdata),
		.coreWe    (coreWe),
		.hostValid (hostValid),
		.hostWrite (hostWrite),
		.hostAddr  (hostAddr),
		.hostWdata (hostWdata),
		.rspReady  (rspReady),
		.rdata     (rdata),
		.startReq  (startReq),
		.hostReady (hostReady),
		.rspValid  (rspValid),
		.rspData   (rspData),
		.address   (address),
		.wdata     (wdata),
		.we        (we),
		.start     (start)
	);

	upMemory #(
		.watchAddr (watchAddr)
	) memory (
		.clk     (clk),
		.nRst    (nRst),
		.address (address),
		.wdata   (wdata),
		.we      (we),
		.rdata   (rdata),
		.watch   (watch)
	);

endmodule

`default_nettype wire

// ==== sim.f ====
hw/upPkg.sv
hw/upMemory.sv
hw/upDecoder.sv
hw/upAlu.sv
hw/upControl.sv
hw/upHostPort.sv
hw/upTop.sv
dv/upTb.sv
